//--- slowVramPkg.sv
package slowVramPkg;

	// Word address into the 32K slow VRAM
	typedef logic [14:0] vramAddr_t;

	// One slow VRAM word
	typedef logic [15:0] vramData_t;

	// Fix layer tile number
	typedef logic [11:0] fixTile_t;

	// Full sprite tile number
	// Low 16 bits from the even word, top 4 from the odd word
	typedef logic [19:0] sprTile_t;

	// Sprite palette index
	typedef logic [7:0] palIdx_t;

	// Active sprite number, 381 sprites fit in 9 bits
	typedef logic [8:0] spriteIdx_t;

	// Access slots in the order the counter walks them
	typedef enum logic [1:0] {
		SLOT_SPR_EVEN,
		SLOT_SPR_ODD,
		SLOT_FIX,
		SLOT_CPU
	} slot_t;

	// Array read pipeline depth
	// Must stay within 1..3 since capture is at phase 3
	parameter int READ_LATENCY_DEF = 2;

	// Fix map lives at the top of the slow VRAM
	parameter vramAddr_t FIX_MAP_BASE_DEF = 15'h7000;

endpackage

//--- slowCycleSeq.sv
`timescale 1ns/10ps

module slowCycleSeq #(
	// Start of the fix map in VRAM
	parameter slowVramPkg::vramAddr_t FIX_MAP_BASE = slowVramPkg::FIX_MAP_BASE_DEF
) (
	input logic CLK_24M,
	input logic rstN,
	// Fix map position
	input logic [5:0] fixCol,
	input logic [4:0] rasterRow,
	// Sprite map position
	input slowVramPkg::spriteIdx_t activeSprite,
	input logic [4:0] tileRow,
	// CPU port, write and read are one-clock pulses
	input slowVramPkg::vramAddr_t cpuAddr,
	input slowVramPkg::vramData_t cpuWriteData,
	input logic cpuWrite,
	input logic cpuRead,
	// Array side
	output slowVramPkg::vramAddr_t vramAddr,
	output slowVramPkg::vramData_t vramWriteData,
	output logic vramRd,
	output logic vramWr,
	// Tag for the read latch
	output logic capture,
	output slowVramPkg::slot_t captureSlot,
	output logic cpuBusy
);
	import slowVramPkg::*;

	// Free running cycle position
	// 16 clocks per slow cycle, 4 per slot
	logic [3:0] slotCnt;
	logic [1:0] phase;
	slot_t curSlot;
	slot_t nextSlot;
	logic slotEnd;
	// Set when the current slot issued a read
	logic slotRead;
	// Sprite coordinates held for both sprite slots
	spriteIdx_t sprIdxHeld;
	logic [4:0] tileRowHeld;
	// Pending CPU request
	logic cpuIsWrite;
	vramAddr_t cpuAddrHeld;
	vramData_t cpuDataHeld;
	logic cpuAccept;
	// Decisions for the coming slot
	logic issueRd;
	logic issueWr;
	vramAddr_t fixAddr;
	vramAddr_t nextAddr;

	assign phase = slotCnt[1:0];
	assign curSlot = slot_t'(slotCnt[3:2]);
	// Wraps from CPU back to even sprite word
	assign nextSlot = slot_t'(slotCnt[3:2] + 2'd1);
	// Last clock of a slot, next slot is set up here
	assign slotEnd = (phase == 2'd3);

	// Fix map is column major, 32 words per column
	assign fixAddr = FIX_MAP_BASE + {4'd0, fixCol, 5'd0} + {10'd0, rasterRow};

	// New request only taken while idle
	assign cpuAccept = !cpuBusy && (cpuWrite || cpuRead);

	always_comb begin
		issueRd = 1'b0;
		issueWr = 1'b0;
		if (slotEnd) begin
			case (nextSlot)
				SLOT_SPR_EVEN: issueRd = 1'b1;
				// Odd word only if its even partner was read
				SLOT_SPR_ODD: issueRd = slotRead;
				SLOT_FIX: issueRd = 1'b1;
				SLOT_CPU: begin
					issueRd = cpuBusy && !cpuIsWrite;
					issueWr = cpuBusy && cpuIsWrite;
				end
			endcase
		end
	end

	// Address mux for the coming slot
	always_comb begin
		case (nextSlot)
			// Live coordinates, same values get latched below
			SLOT_SPR_EVEN: nextAddr = {activeSprite, tileRow, 1'b0};
			SLOT_SPR_ODD: nextAddr = {sprIdxHeld, tileRowHeld, 1'b1};
			SLOT_FIX: nextAddr = fixAddr;
			default: nextAddr = cpuAddrHeld;
		endcase
	end

	always_ff @(posedge CLK_24M or negedge rstN) begin
		if (!rstN) begin
			slotCnt <= 4'd0;
			vramRd <= 1'b0;
			vramWr <= 1'b0;
			slotRead <= 1'b0;
			capture <= 1'b0;
			captureSlot <= SLOT_SPR_EVEN;
			cpuBusy <= 1'b0;
			cpuIsWrite <= 1'b0;
		end else begin
			slotCnt <= slotCnt + 4'd1;
			// Strobes land in phase 0
			vramRd <= issueRd;
			vramWr <= issueWr;
			if (slotEnd)
				slotRead <= issueRd;
			// Word is back by phase 3, latch takes it at end of phase 3
			capture <= (phase == 2'd2) && slotRead;
			if (phase == 2'd2)
				captureSlot <= curSlot;
			if (cpuAccept) begin
				cpuBusy <= 1'b1;
				cpuIsWrite <= cpuWrite;
			end else if (vramWr || (capture && captureSlot == SLOT_CPU)) begin
				// Write done after its strobe, read done after its capture
				cpuBusy <= 1'b0;
			end
		end
	end

	always_ff @(posedge CLK_24M) begin
		if (slotEnd)
			vramAddr <= nextAddr;
		if (issueWr)
			vramWriteData <= cpuDataHeld;
		// Sample sprite coordinates at start of slot 0
		if (slotEnd && nextSlot == SLOT_SPR_EVEN) begin
			sprIdxHeld <= activeSprite;
			tileRowHeld <= tileRow;
		end
		if (cpuAccept) begin
			cpuAddrHeld <= cpuAddr;
			cpuDataHeld <= cpuWriteData;
		end
	end

endmodule

//--- slowVramArray.sv
`timescale 1ns/10ps

module slowVramArray #(
	// Clocks from read strobe to data out
	parameter int READ_LATENCY = slowVramPkg::READ_LATENCY_DEF
) (
	input logic CLK_24M,
	input logic rstN,
	input slowVramPkg::vramAddr_t vramAddr,
	input slowVramPkg::vramData_t vramWriteData,
	input logic vramRd,
	input logic vramWr,
	output slowVramPkg::vramData_t vramReadData
);
	import slowVramPkg::*;

	// One word per address
	localparam int WORDS = 1 << $bits(vramAddr_t);

	vramData_t mem [WORDS];

	// Read pipeline
	// Each stage may hold a different slot's word
	vramData_t readPipe [READ_LATENCY];

	// Write takes effect at the end of the strobe clock
	always_ff @(posedge CLK_24M) begin
		if (vramWr)
			mem[vramAddr] <= vramWriteData;
	end

	always_ff @(posedge CLK_24M or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < READ_LATENCY; i++)
				readPipe[i] <= '0;
		end else begin
			// Idle clocks keep the last word so it lasts until phase 3
			if (vramRd)
				readPipe[0] <= mem[vramAddr];
			for (int i = 1; i < READ_LATENCY; i++)
				readPipe[i] <= readPipe[i - 1];
		end
	end

	// Last stage drives the bus
	assign vramReadData = readPipe[READ_LATENCY - 1];

endmodule

//--- slowReadLatch.sv
`timescale 1ns/10ps

module slowReadLatch (
	input logic CLK_24M,
	input logic rstN,
	input slowVramPkg::vramData_t vramReadData,
	input logic capture,
	input slowVramPkg::slot_t captureSlot,
	// Fix map fields
	output slowVramPkg::fixTile_t fixTile,
	output logic [3:0] fixPal,
	output logic fixValid,
	// Sprite map fields
	output slowVramPkg::sprTile_t sprTile,
	output slowVramPkg::palIdx_t sprPal,
	output logic [1:0] sprAutoAnim,
	output logic sprVFlip,
	output logic sprHFlip,
	output logic sprValid,
	// CPU readback
	output slowVramPkg::vramData_t cpuReadData,
	output logic cpuReadValid
);
	import slowVramPkg::*;

	// First stage, raw word and its slot
	vramData_t word;
	slot_t wordSlot;
	logic wordValid;
	// Even sprite word waits for its odd partner
	vramData_t evenHold;

	// Capture stage
	always_ff @(posedge CLK_24M or negedge rstN) begin
		if (!rstN) begin
			wordValid <= 1'b0;
			wordSlot <= SLOT_SPR_EVEN;
		end else begin
			wordValid <= capture;
			if (capture)
				wordSlot <= captureSlot;
		end
	end

	always_ff @(posedge CLK_24M) begin
		if (capture)
			word <= vramReadData;
		if (wordValid && wordSlot == SLOT_SPR_EVEN)
			evenHold <= word;
	end

	// Field stage, one clock after capture
	always_ff @(posedge CLK_24M or negedge rstN) begin
		if (!rstN) begin
			fixTile <= '0;
			fixPal <= 4'd0;
			fixValid <= 1'b0;
			sprTile <= '0;
			sprPal <= '0;
			sprAutoAnim <= 2'd0;
			sprVFlip <= 1'b0;
			sprHFlip <= 1'b0;
			sprValid <= 1'b0;
			cpuReadData <= '0;
			cpuReadValid <= 1'b0;
		end else begin
			// Valids are single clock pulses
			fixValid <= 1'b0;
			sprValid <= 1'b0;
			cpuReadValid <= 1'b0;
			if (wordValid) begin
				case (wordSlot)
					SLOT_FIX: begin
						fixTile <= word[11:0];
						fixPal <= word[15:12];
						fixValid <= 1'b1;
					end
					// All sprite fields change together on the odd word
					SLOT_SPR_ODD: begin
						sprTile <= {word[7:4], evenHold};
						sprPal <= word[15:8];
						sprAutoAnim <= word[3:2];
						sprVFlip <= word[1];
						sprHFlip <= word[0];
						sprValid <= 1'b1;
					end
					SLOT_CPU: begin
						cpuReadData <= word;
						cpuReadValid <= 1'b1;
					end
					// Even word only parked in evenHold
					default: ;
				endcase
			end
		end
	end

endmodule

//--- slowCycle.sv
`timescale 1ns/10ps

module slowCycle #(
	parameter int READ_LATENCY = slowVramPkg::READ_LATENCY_DEF,
	parameter slowVramPkg::vramAddr_t FIX_MAP_BASE = slowVramPkg::FIX_MAP_BASE_DEF
) (
	input logic CLK_24M,
	input logic rstN,
	// Raster and sprite position
	input logic [5:0] fixCol,
	input logic [4:0] rasterRow,
	input slowVramPkg::spriteIdx_t activeSprite,
	input logic [4:0] tileRow,
	// CPU port
	input slowVramPkg::vramAddr_t cpuAddr,
	input slowVramPkg::vramData_t cpuWriteData,
	input logic cpuWrite,
	input logic cpuRead,
	output logic cpuBusy,
	// Decoded map fields
	output slowVramPkg::fixTile_t fixTile,
	output logic [3:0] fixPal,
	output logic fixValid,
	output slowVramPkg::sprTile_t sprTile,
	output slowVramPkg::palIdx_t sprPal,
	output logic [1:0] sprAutoAnim,
	output logic sprVFlip,
	output logic sprHFlip,
	output logic sprValid,
	output slowVramPkg::vramData_t cpuReadData,
	output logic cpuReadValid
);
	import slowVramPkg::*;

	// Sequencer to array
	vramAddr_t vramAddr;
	vramData_t vramWriteData;
	logic vramRd;
	logic vramWr;
	// Array to latch
	vramData_t vramReadData;
	// Sequencer to latch
	logic capture;
	slot_t captureSlot;

	// Slot timing, address mux, CPU request
	slowCycleSeq #(
		.FIX_MAP_BASE(FIX_MAP_BASE)
	) seq (
		.CLK_24M(CLK_24M), .rstN(rstN),
		.fixCol(fixCol), .rasterRow(rasterRow),
		.activeSprite(activeSprite), .tileRow(tileRow),
		.cpuAddr(cpuAddr), .cpuWriteData(cpuWriteData),
		.cpuWrite(cpuWrite), .cpuRead(cpuRead),
		.vramAddr(vramAddr), .vramWriteData(vramWriteData),
		.vramRd(vramRd), .vramWr(vramWr),
		.capture(capture), .captureSlot(captureSlot), .cpuBusy(cpuBusy)
	);

	// Slow VRAM with pipelined reads
	slowVramArray #(
		.READ_LATENCY(READ_LATENCY)
	) vram (
		.CLK_24M(CLK_24M), .rstN(rstN),
		.vramAddr(vramAddr), .vramWriteData(vramWriteData),
		.vramRd(vramRd), .vramWr(vramWr), .vramReadData(vramReadData)
	);

	// Field split per slot
	slowReadLatch latch (
		.CLK_24M(CLK_24M), .rstN(rstN),
		.vramReadData(vramReadData), .capture(capture), .captureSlot(captureSlot),
		.fixTile(fixTile), .fixPal(fixPal), .fixValid(fixValid),
		.sprTile(sprTile), .sprPal(sprPal), .sprAutoAnim(sprAutoAnim),
		.sprVFlip(sprVFlip), .sprHFlip(sprHFlip), .sprValid(sprValid),
		.cpuReadData(cpuReadData), .cpuReadValid(cpuReadValid)
	);

endmodule

//--- slowCycle_props.sv
`timescale 1ns/10ps

module slowCycleProps (
	input logic CLK_24M,
	input logic rstN,
	input logic [1:0] phase,
	input logic vramRd,
	input logic vramWr,
	input logic capture,
	input logic cpuBusy
);
	// Clocks in a row with a CPU request pending
	int busyClocks;

	always_ff @(posedge CLK_24M or negedge rstN) begin
		if (!rstN)
			busyClocks <= 0;
		else if (cpuBusy)
			busyClocks <= busyClocks + 1;
		else
			busyClocks <= 0;
	end

	// One access per slot
	strobeExclusive: assert property (@(posedge CLK_24M) disable iff (!rstN)
		!(vramRd && vramWr)) else $error("vramRd and vramWr high together");

	// Strobes only at slot start
	strobePhase: assert property (@(posedge CLK_24M) disable iff (!rstN)
		(vramRd || vramWr) |-> phase == 2'd0) else $error("strobe outside phase 0");

	// Capture tag trails its read by 3 clocks, both ways
	captureAfterRead: assert property (@(posedge CLK_24M) disable iff (!rstN)
		capture |-> $past(vramRd, 3)) else $error("capture without read 3 clocks before");
	readThenCapture: assert property (@(posedge CLK_24M) disable iff (!rstN)
		$past(vramRd, 3) |-> capture) else $error("read not captured 3 clocks later");

	// Worst case is a read accepted just after the CPU slot passed
	busyBounded: assert property (@(posedge CLK_24M) disable iff (!rstN)
		busyClocks <= 20) else $error("cpuBusy high for more than 20 clocks");

endmodule

bind slowCycleSeq slowCycleProps props (
	.CLK_24M(CLK_24M), .rstN(rstN), .phase(phase),
	.vramRd(vramRd), .vramWr(vramWr), .capture(capture), .cpuBusy(cpuBusy)
);

//--- slowCycleTb.sv
`timescale 1ns/10ps

module slowCycleTb;
	import slowVramPkg::*;

	// 44 CPU accesses of up to 20 clocks plus read latency
	// Plus 11 fetch waits of one slow cycle and some margin
	localparam int TIMEOUT_CYCLES = 44 * (20 + READ_LATENCY_DEF) + 11 * 16 + 56;

	logic CLK_24M;
	logic rstN;
	logic [5:0] fixCol;
	logic [4:0] rasterRow;
	spriteIdx_t activeSprite;
	logic [4:0] tileRow;
	vramAddr_t cpuAddr;
	vramData_t cpuWriteData;
	logic cpuWrite;
	logic cpuRead;
	logic cpuBusy;
	fixTile_t fixTile;
	logic [3:0] fixPal;
	logic fixValid;
	sprTile_t sprTile;
	palIdx_t sprPal;
	logic [1:0] sprAutoAnim;
	logic sprVFlip;
	logic sprHFlip;
	logic sprValid;
	vramData_t cpuReadData;
	logic cpuReadValid;

	// Mirror of every accepted write
	vramData_t shadow [32768];
	logic [31:0] rngState;
	string curTest;
	int testErrors;
	int errorCount;
	int checkCount;
	int testCount;
	int cycleCount;

	slowCycle #(.READ_LATENCY(READ_LATENCY_DEF), .FIX_MAP_BASE(FIX_MAP_BASE_DEF)) DUT (.*);

	initial begin
		CLK_24M = 1'b0;
		forever #20 CLK_24M = ~CLK_24M;
	end

	// Run limit
	initial begin
		cycleCount = 0;
		while (cycleCount < TIMEOUT_CYCLES) begin
			@(posedge CLK_24M);
			cycleCount++;
		end
		$display("Timeout, tests still running after %0d clocks", cycleCount);
		$display("Simulation FAILED");
		$finish;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		return y ^ (y << 5);
	endfunction

	function automatic vramData_t randWord();
		rngState = xorshift32(rngState);
		return rngState[15:0];
	endfunction

	// Fix map: 32 rows per column above the base
	function automatic vramAddr_t fixMapAddr(input logic [5:0] col, input logic [4:0] row);
		return FIX_MAP_BASE_DEF + vramAddr_t'(32 * int'(col) + int'(row));
	endfunction

	// Sprite map: 64 words per sprite, word pair per tile row
	function automatic vramAddr_t sprMapAddr(input spriteIdx_t idx, input logic [4:0] row,
		input logic odd);
		return vramAddr_t'(64 * int'(idx) + 2 * int'(row) + int'(odd));
	endfunction

	// Inputs change 2 ns after the edge, outputs read there too
	task automatic nextClock();
		@(posedge CLK_24M);
		#2;
	endtask

	task automatic showMismatch(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		$display("ERR %s %s: expected %h, actual %h", curTest, what, expected, actual);
		testErrors++;
	endtask

	task automatic flagFailure(input string what);
		$display("%s failed: %s", curTest, what);
		testErrors++;
	endtask

	task automatic openTest(input string name);
		curTest = name;
		testErrors = 0;
		testCount++;
	endtask

	task automatic closeTest();
		$display("%s done with %0d errors", curTest, testErrors);
		errorCount += testErrors;
	endtask

	task automatic waitIdle();
		int n;
		n = 0;
		while (cpuBusy && n < 30) begin
			nextClock();
			n++;
		end
		if (cpuBusy)
			flagFailure("cpuBusy stuck high");
	endtask

	task automatic writeWord(input vramAddr_t addr, input vramData_t data);
		cpuAddr = addr;
		cpuWriteData = data;
		cpuWrite = 1'b1;
		nextClock();
		cpuWrite = 1'b0;
		if (!cpuBusy)
			flagFailure("write request not accepted");
		waitIdle();
		shadow[addr] = data;
	endtask

	task automatic readBack(input vramAddr_t addr);
		int n;
		cpuAddr = addr;
		cpuRead = 1'b1;
		nextClock();
		cpuRead = 1'b0;
		if (!cpuBusy)
			flagFailure("read request not accepted");
		n = 0;
		while (!cpuReadValid && n < 30) begin
			nextClock();
			n++;
		end
		if (!cpuReadValid) begin
			flagFailure("cpuReadValid never pulsed");
		end else begin
			checkCount++;
			if (cpuReadData !== shadow[addr])
				showMismatch("cpuReadData", 32'(shadow[addr]), 32'(cpuReadData));
		end
	endtask

	// Next fixValid or sprValid, within one slow cycle
	task automatic waitFetch(input logic sprite);
		int n;
		n = 0;
		do begin
			nextClock();
			n++;
		end while (!(sprite ? sprValid : fixValid) && n < 40);
		if (!(sprite ? sprValid : fixValid))
			flagFailure(sprite ? "sprValid did not pulse" : "fixValid did not pulse");
	endtask

	task automatic fixFieldsCheck(input logic [5:0] col, input logic [4:0] row);
		vramData_t w;
		w = shadow[fixMapAddr(col, row)];
		checkCount += 2;
		if (fixTile !== w[11:0])
			showMismatch("fixTile", 32'(w[11:0]), 32'(fixTile));
		if (fixPal !== w[15:12])
			showMismatch("fixPal", 32'(w[15:12]), 32'(fixPal));
	endtask

	task automatic spriteFieldsCheck(input spriteIdx_t idx, input logic [4:0] row);
		vramData_t even;
		vramData_t odd;
		sprTile_t expTile;
		even = shadow[sprMapAddr(idx, row, 1'b0)];
		odd = shadow[sprMapAddr(idx, row, 1'b1)];
		// Odd word carries tile bits 19..16 in its bits 7..4
		expTile = {odd[7:4], even};
		checkCount += 5;
		if (sprTile !== expTile)
			showMismatch("sprTile", 32'(expTile), 32'(sprTile));
		if (sprPal !== odd[15:8])
			showMismatch("sprPal", 32'(odd[15:8]), 32'(sprPal));
		if (sprAutoAnim !== odd[3:2])
			showMismatch("sprAutoAnim", 32'(odd[3:2]), 32'(sprAutoAnim));
		if (sprVFlip !== odd[1])
			showMismatch("sprVFlip", 32'(odd[1]), 32'(sprVFlip));
		if (sprHFlip !== odd[0])
			showMismatch("sprHFlip", 32'(odd[0]), 32'(sprHFlip));
	endtask

	task automatic resetValues();
		openTest("reset");
		checkCount += 5;
		if ({cpuBusy, fixValid, sprValid, cpuReadValid} !== 4'd0)
			showMismatch("busy and valids", 32'd0,
				32'({cpuBusy, fixValid, sprValid, cpuReadValid}));
		if ({fixTile, fixPal} !== 16'd0)
			showMismatch("fix fields", 32'd0, 32'({fixTile, fixPal}));
		if (sprTile !== 20'd0)
			showMismatch("sprTile", 32'd0, 32'(sprTile));
		if ({sprPal, sprAutoAnim, sprVFlip, sprHFlip} !== 12'd0)
			showMismatch("sprite flags", 32'd0, 32'({sprPal, sprAutoAnim, sprVFlip, sprHFlip}));
		if (cpuReadData !== 16'd0)
			showMismatch("cpuReadData", 32'd0, 32'(cpuReadData));
		closeTest();
	endtask

	task automatic cpuRoundTrip();
		vramAddr_t addr;
		openTest("cpuRoundTrip");
		for (int i = 0; i < 12; i++) begin
			// Stay below the fix map
			addr = vramAddr_t'(randWord() % 16'h7000);
			writeWord(addr, randWord());
			readBack(addr);
		end
		closeTest();
	endtask

	task automatic fixFetch();
		openTest("fixFetch");
		fixCol = 6'd17;
		rasterRow = 5'd9;
		writeWord(fixMapAddr(fixCol, rasterRow), randWord());
		// Write lands in slot 3, so the next fetch already sees it
		waitFetch(1'b0);
		fixFieldsCheck(fixCol, rasterRow);
		closeTest();
	endtask

	task automatic spritePair();
		openTest("spritePair");
		activeSprite = 9'd300;
		tileRow = 5'd21;
		writeWord(sprMapAddr(activeSprite, tileRow, 1'b0), randWord());
		writeWord(sprMapAddr(activeSprite, tileRow, 1'b1), randWord());
		waitFetch(1'b1);
		spriteFieldsCheck(activeSprite, tileRow);
		closeTest();
	endtask

	task automatic ignoredRequest();
		vramAddr_t addrA;
		vramAddr_t addrB;
		vramData_t firstData;
		openTest("ignoredRequest");
		firstData = randWord();
		addrA = {1'b0, firstData[13:0]};
		addrB = addrA ^ 15'h2aaa;
		writeWord(addrB, randWord());
		firstData = randWord();
		cpuAddr = addrA;
		cpuWriteData = firstData;
		cpuWrite = 1'b1;
		nextClock();
		cpuWrite = 1'b0;
		if (!cpuBusy)
			flagFailure("first write not accepted");
		nextClock();
		// Second pulse while the first is still pending
		cpuAddr = addrB;
		cpuWriteData = ~firstData;
		cpuWrite = 1'b1;
		nextClock();
		cpuWrite = 1'b0;
		shadow[addrA] = firstData;
		waitIdle();
		readBack(addrA);
		readBack(addrB);
		closeTest();
	endtask

	task automatic changingInputs();
		openTest("changingInputs");
		for (int i = 0; i < 4; i++) begin
			writeWord(fixMapAddr(6'(i * 21), 5'(31 - i * 9)), randWord());
			writeWord(sprMapAddr(9'(i * 149), 5'(i * 7 + 2), 1'b0), randWord());
			writeWord(sprMapAddr(9'(i * 149), 5'(i * 7 + 2), 1'b1), randWord());
		end
		// Change right after fixValid, before the next slot 0 samples
		waitFetch(1'b0);
		for (int i = 0; i < 4; i++) begin
			fixCol = 6'(i * 21);
			rasterRow = 5'(31 - i * 9);
			activeSprite = 9'(i * 149);
			tileRow = 5'(i * 7 + 2);
			waitFetch(1'b1);
			spriteFieldsCheck(activeSprite, tileRow);
			waitFetch(1'b0);
			fixFieldsCheck(fixCol, rasterRow);
		end
		closeTest();
	endtask

	initial begin
		rngState = 32'h8a06;
		errorCount = 0;
		checkCount = 0;
		testCount = 0;
		rstN = 1'b0;
		fixCol = 6'd0;
		rasterRow = 5'd0;
		activeSprite = 9'd0;
		tileRow = 5'd0;
		cpuAddr = 15'd0;
		cpuWriteData = 16'd0;
		cpuWrite = 1'b0;
		cpuRead = 1'b0;
		repeat (3) @(posedge CLK_24M);
		#2;
		rstN = 1'b1;
		resetValues();
		cpuRoundTrip();
		fixFetch();
		spritePair();
		ignoredRequest();
		changingInputs();
		$display("Tests %0d, checks %0d, errors %0d", testCount, checkCount, errorCount);
		if (errorCount == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

//--- slowVram.f
slowVramPkg.sv
slowCycleSeq.sv
slowVramArray.sv
slowReadLatch.sv
slowCycle.sv
slowCycle_props.sv
slowCycleTb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the slow VRAM cycle testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/10ps \
	--top-module slowCycleTb -Mdir "$BUILD_DIR" -o slowCycleSim -f slowVram.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$BUILD_DIR/slowCycleSim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

# The log decides the result
if grep -q "Simulation FAILED" "$LOG"; then
	exit 1
fi
exit 0
